//--- host_bus_core.f
host_core_pkg.sv
host_bus_bridge.sv
wb_single_master_ic.sv
misc_regs.sv
uart_tx_slave.sv
host_bus_core.sv
host_bus_core_asserts.sv
host_bus_core_tb.sv

//--- Makefile
# Verilator build and run for the host bus core testbench

VERILATOR ?= verilator
TOP       ?= host_bus_core_tb
FILELIST  ?= host_bus_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- host_bus_core_tb.sv
`timescale 1ns/10ps

module host_bus_core_tb;
   import host_core_pkg::*;

   localparam int DEPTH_LOG2 = 2;
   localparam int DEPTH      = 1 << DEPTH_LOG2;
   localparam int TB_CLKDIV  = 8;
   localparam int N_RAND     = 24;
   localparam int N_BURSTS   = 4;
   localparam int MAX_DIV    = 12;
   // Worst case run length in clocks
   localparam int MAX_XFERS  = 8 * N_RAND + N_BURSTS * (DEPTH + 3) + 16;
   localparam int MAX_BYTES  = N_BURSTS * DEPTH + DEPTH + 1;
   localparam int RUN_CYCLES = 10 + MAX_XFERS * 6 + MAX_BYTES * (10 * MAX_DIV + 8);
   // Twice the worst case for margin
   localparam int WATCHDOG_NS = 2 * 10 * RUN_CYCLES;

   logic       wb_clk;
   logic       reset_i;
   logic       host_req_i;
   logic       host_we_i;
   wb_adr_t    host_adr_i;
   wb_dat_t    host_wdata_i;
   logic       host_busy_o;
   logic       host_done_o;
   wb_dat_t    host_rdata_o;
   logic [7:0] dip_sw_i;
   logic [2:0] push_btn_i;
   logic [2:0] led_o;
   logic [3:0] gpio_o;
   logic       uart_tx_o;

   // Reference model state
   wb_dat_t    fast_exp;
   logic [3:0] gpio_exp;
   int         clkdiv_exp;
   logic [7:0] tx_queue[$];
   int         errors;

   host_bus_core #(
      .CLKDIV_DEFAULT(TB_CLKDIV),
      .TX_DEPTH_LOG2 (DEPTH_LOG2)
   ) i_host_bus_core (
      .wb_clk      (wb_clk),
      .reset_i     (reset_i),
      .host_req_i  (host_req_i),
      .host_we_i   (host_we_i),
      .host_adr_i  (host_adr_i),
      .host_wdata_i(host_wdata_i),
      .host_busy_o (host_busy_o),
      .host_done_o (host_done_o),
      .host_rdata_o(host_rdata_o),
      .dip_sw_i    (dip_sw_i),
      .push_btn_i  (push_btn_i),
      .led_o       (led_o),
      .gpio_o      (gpio_o),
      .uart_tx_o   (uart_tx_o)
   );

   initial wb_clk = 1'b0;
   always #5 wb_clk = ~wb_clk;

   task automatic report_mismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
   endtask

   function automatic wb_adr_t uart_adr(input logic [2:0] idx);
      return {SLOT_UART, 2'b00, idx, 2'b00};
   endfunction

   // One host request from 1 ns after a rising edge until its done pulse
   task automatic host_xfer(input logic we, input wb_adr_t adr, input wb_dat_t wdata,
                            output wb_dat_t rdata);
      int waited;
      waited       = 0;
      host_req_i   = 1'b1;
      host_we_i    = we;
      host_adr_i   = adr;
      host_wdata_i = wdata;
      @(posedge wb_clk);
      #1;
      host_req_i = 1'b0;
      if (host_busy_o !== 1'b1) report_mismatch("host_busy_o", 16'(host_busy_o), 16'h0001);
      while (!host_done_o && waited < 20) begin
         @(posedge wb_clk);
         #1;
         waited++;
      end
      if (!host_done_o) begin
         errors++;
         $display("Transfer to address 0x%h never finished", adr);
      end
      if (host_busy_o !== 1'b0) report_mismatch("host_busy_o", 16'(host_busy_o), 16'h0000);
      rdata = host_rdata_o;
      @(posedge wb_clk);
      #1;
      if (host_done_o !== 1'b0) report_mismatch("host_done_o", 16'(host_done_o), 16'h0000);
   endtask

   // Wait until every queued byte is seen and the transmitter is idle
   task automatic drain_uart();
      wb_dat_t st;
      st = 16'h0002;
      while (tx_queue.size() != 0) begin
         @(posedge wb_clk);
         #1;
      end
      while (st[1] !== 1'b0) begin
         host_xfer(1'b0, uart_adr(UART_REG_STATUS), 16'h0000, st);
      end
      if (st !== 16'h0000) report_mismatch("host_rdata_o (STATUS idle)", st, 16'h0000);
   endtask

   ////////////////////////////////////////
   // Serial monitor sampling each bit in its middle
   initial begin : serial_monitor
      logic [7:0] rx;
      int         bit_div;
      @(negedge reset_i);
      forever begin
         @(negedge uart_tx_o);
         bit_div = clkdiv_exp;
         repeat (bit_div / 2) @(posedge wb_clk);
         @(negedge wb_clk);
         if (uart_tx_o !== 1'b0) begin
            errors++;
            $display("UART start bit was not low in the middle of the bit");
         end
         for (int i = 0; i < 8; i++) begin
            repeat (bit_div) @(posedge wb_clk);
            @(negedge wb_clk);
            rx[i] = uart_tx_o;
         end
         repeat (bit_div) @(posedge wb_clk);
         @(negedge wb_clk);
         if (uart_tx_o !== 1'b1) begin
            errors++;
            $display("UART stop bit was not high after byte 0x%h", rx);
         end
         if (tx_queue.size() == 0) begin
            errors++;
            $display("UART sent byte 0x%h that was never expected", rx);
         end else begin
            if (rx !== tx_queue[0]) report_mismatch("uart_tx_o", 16'(rx), 16'(tx_queue[0]));
            void'(tx_queue.pop_front());
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("Errors: %0d", errors);
      $display("tests failed");
      $finish;
   end

   initial begin : main_sequence
      wb_dat_t    rd;
      wb_dat_t    wd;
      wb_dat_t    sw_exp;
      logic [2:0] led_exp;
      logic [6:0] off;
      slot_t      slot;
      int         n;
      int         accepted;
      int         assert_fails;

      errors       = 0;
      void'($urandom(32'hfd4f_8277));
      reset_i      = 1'b1;
      host_req_i   = 1'b0;
      host_we_i    = 1'b0;
      host_adr_i   = '0;
      host_wdata_i = '0;
      dip_sw_i     = '0;
      push_btn_i   = '0;
      fast_exp     = '0;
      gpio_exp     = '0;
      clkdiv_exp   = TB_CLKDIV;
      repeat (10) @(posedge wb_clk);
      #1;
      reset_i = 1'b0;

      // Reset values
      if (led_o !== 3'b000) report_mismatch("led_o", 16'(led_o), 16'h0000);
      if (gpio_o !== 4'h0) report_mismatch("gpio_o", 16'(gpio_o), 16'h0000);
      if (uart_tx_o !== 1'b1) report_mismatch("uart_tx_o", 16'(uart_tx_o), 16'h0001);
      if (host_busy_o !== 1'b0) report_mismatch("host_busy_o", 16'(host_busy_o), 16'h0000);
      host_xfer(1'b0, uart_adr(UART_REG_CLKDIV), 16'h0000, rd);
      if (rd !== 16'(TB_CLKDIV)) report_mismatch("host_rdata_o (CLKDIV)", rd, 16'(TB_CLKDIV));

      // Fast register and LED bit order
      for (int i = 0; i < N_RAND; i++) begin
         wd = 16'($urandom);
         host_xfer(1'b1, {SLOT_MISC, MISC_REG_FAST}, wd, rd);
         fast_exp = wd;
         host_xfer(1'b0, {SLOT_MISC, MISC_REG_FAST}, 16'h0000, rd);
         if (rd !== fast_exp) report_mismatch("host_rdata_o (fast)", rd, fast_exp);
         // LED 1 shows bit 0 and LED 0 shows bit 1
         led_exp[0] = fast_exp[1];
         led_exp[1] = fast_exp[0];
         led_exp[2] = fast_exp[2];
         if (led_o !== led_exp) report_mismatch("led_o", 16'(led_o), 16'(led_exp));
      end

      // Switches, buttons and filler offsets
      for (int i = 0; i < N_RAND; i++) begin
         dip_sw_i   = 8'($urandom);
         push_btn_i = 3'($urandom);
         host_xfer(1'b0, {SLOT_MISC, MISC_REG_SWITCHES}, 16'h0000, rd);
         sw_exp = (16'(push_btn_i) << 8) | 16'(dip_sw_i);
         if (rd !== sw_exp) report_mismatch("host_rdata_o (switches)", rd, sw_exp);
         off = 7'($urandom);
         if (off == MISC_REG_FAST || off == MISC_REG_SWITCHES) off = MISC_REG_GPIOS;
         host_xfer(1'b0, {SLOT_MISC, off}, 16'h0000, rd);
         if (rd !== 16'hBEEF) report_mismatch("host_rdata_o (filler)", rd, 16'hBEEF);
      end

      // GPIO outputs, the register itself reads as filler
      for (int i = 0; i < N_RAND; i++) begin
         wd = 16'($urandom);
         host_xfer(1'b1, {SLOT_MISC, MISC_REG_GPIOS}, wd, rd);
         gpio_exp = wd[3:0];
         if (gpio_o !== gpio_exp) report_mismatch("gpio_o", 16'(gpio_o), 16'(gpio_exp));
         host_xfer(1'b0, {SLOT_MISC, MISC_REG_GPIOS}, 16'h0000, rd);
         if (rd !== 16'hBEEF) report_mismatch("host_rdata_o (GPIO read)", rd, 16'hBEEF);
      end

      // Empty slots read zero and swallow writes
      for (int i = 0; i < N_RAND; i++) begin
         slot = slot_t'($urandom_range(15, 2));
         off  = 7'($urandom);
         host_xfer(1'b0, {slot, off}, 16'h0000, rd);
         if (rd !== 16'h0000) report_mismatch("host_rdata_o (empty slot)", rd, 16'h0000);
         host_xfer(1'b1, {slot, off}, 16'($urandom), rd);
      end
      host_xfer(1'b0, {SLOT_MISC, MISC_REG_FAST}, 16'h0000, rd);
      if (rd !== fast_exp) report_mismatch("host_rdata_o (fast)", rd, fast_exp);
      if (gpio_o !== gpio_exp) report_mismatch("gpio_o", 16'(gpio_o), 16'(gpio_exp));

      ////////////////////////////////////////
      // UART bursts within the FIFO depth
      for (int b = 0; b < N_BURSTS; b++) begin
         wd = 16'($urandom_range(MAX_DIV, 4));
         host_xfer(1'b1, uart_adr(UART_REG_CLKDIV), wd, rd);
         clkdiv_exp = int'(wd);
         host_xfer(1'b0, uart_adr(UART_REG_CLKDIV), 16'h0000, rd);
         if (rd !== wd) report_mismatch("host_rdata_o (CLKDIV)", rd, wd);
         n = int'($urandom_range(DEPTH, 1));
         for (int i = 0; i < n; i++) begin
            wd = 16'($urandom);
            tx_queue.push_back(wd[7:0]);
            host_xfer(1'b1, uart_adr(UART_REG_TXDATA), wd, rd);
         end
         host_xfer(1'b0, uart_adr(UART_REG_STATUS), 16'h0000, rd);
         if (int'(rd[15:8]) > n) report_mismatch("host_rdata_o (fill level)", rd, 16'(n << 8));
         drain_uart();
      end

      // Six bytes into a four entry FIFO
      // The first byte leaves the FIFO as its transmission starts
      accepted = DEPTH + 1;
      for (int i = 0; i < 6; i++) begin
         wd = 16'($urandom);
         if (i < accepted) tx_queue.push_back(wd[7:0]);
         host_xfer(1'b1, uart_adr(UART_REG_TXDATA), wd, rd);
      end
      host_xfer(1'b0, uart_adr(UART_REG_STATUS), 16'h0000, rd);
      if (rd[0] !== 1'b1) report_mismatch("host_rdata_o (STATUS full)", 16'(rd[0]), 16'h0001);
      drain_uart();

      assert_fails = int'(i_host_bus_core.i_wb_single_master_ic.i_host_bus_core_asserts.fail_count);
      $display("Errors: %0d in testbench checks, %0d in bus assertions", errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- host_bus_core_asserts.sv
`timescale 1ns/10ps

module host_bus_core_asserts (
   input logic                   wb_clk,
   input logic                   reset_i,
   input host_core_pkg::wb_m2s_t m_req_i,
   input host_core_pkg::wb_s2m_t m_rsp_o,
   input host_core_pkg::wb_m2s_t s0_req_o,
   input host_core_pkg::wb_m2s_t s1_req_o
);

   int unsigned fail_count = 0;

   ////////////////////////////////////////
   // Wishbone master side
   stb_needs_cyc: assert property (@(posedge wb_clk) disable iff (reset_i)
      m_req_i.stb |-> m_req_i.cyc)
      else begin
         fail_count++;
         $error("stb high without cyc");
      end

   // Request held until ack
   req_stable: assert property (@(posedge wb_clk) disable iff (reset_i)
      (m_req_i.stb && !m_rsp_o.ack) |=> $stable(m_req_i))
      else begin
         fail_count++;
         $error("request changed before ack");
      end

   one_slot: assert property (@(posedge wb_clk) disable iff (reset_i)
      !(s0_req_o.stb && s1_req_o.stb))
      else begin
         fail_count++;
         $error("two slot strobes active");
      end

   single_ack: assert property (@(posedge wb_clk) disable iff (reset_i)
      m_rsp_o.ack |=> !m_rsp_o.ack)
      else begin
         fail_count++;
         $error("ack lasted two cycles");
      end

endmodule

bind wb_single_master_ic host_bus_core_asserts i_host_bus_core_asserts (
   .wb_clk  (wb_clk),
   .reset_i (reset_i),
   .m_req_i (m_req_i),
   .m_rsp_o (m_rsp_o),
   .s0_req_o(s0_req_o),
   .s1_req_o(s1_req_o)
);

//--- host_bus_core.sv
`timescale 1ns/10ps

module host_bus_core #(
   parameter int CLKDIV_DEFAULT = 278,
   parameter int TX_DEPTH_LOG2  = 2
) (
   input  logic                   wb_clk,
   input  logic                   reset_i,
   input  logic                   host_req_i,
   input  logic                   host_we_i,
   input  host_core_pkg::wb_adr_t host_adr_i,
   input  host_core_pkg::wb_dat_t host_wdata_i,
   output logic                   host_busy_o,
   output logic                   host_done_o,
   output host_core_pkg::wb_dat_t host_rdata_o,
   input  logic [7:0]             dip_sw_i,
   input  logic [2:0]             push_btn_i,
   output logic [2:0]             led_o,
   output logic [3:0]             gpio_o,
   output logic                   uart_tx_o
);
   import host_core_pkg::*;

   wb_m2s_t m_req;
   wb_s2m_t m_rsp;
   wb_m2s_t s0_req;
   wb_s2m_t s0_rsp;
   wb_m2s_t s1_req;
   wb_s2m_t s1_rsp;

   ////////////////////////////////////////
   // Host port to Wishbone master
   host_bus_bridge i_host_bus_bridge (
      .wb_clk      (wb_clk),
      .reset_i     (reset_i),
      .host_req_i  (host_req_i),
      .host_we_i   (host_we_i),
      .host_adr_i  (host_adr_i),
      .host_wdata_i(host_wdata_i),
      .host_busy_o (host_busy_o),
      .host_done_o (host_done_o),
      .host_rdata_o(host_rdata_o),
      .wb_req_o    (m_req),
      .wb_rsp_i    (m_rsp)
   );

   wb_single_master_ic i_wb_single_master_ic (
      .wb_clk  (wb_clk),
      .reset_i (reset_i),
      .m_req_i (m_req),
      .m_rsp_o (m_rsp),
      .s0_req_o(s0_req),
      .s0_rsp_i(s0_rsp),
      .s1_req_o(s1_req),
      .s1_rsp_i(s1_rsp)
   );

   ////////////////////////////////////////
   // Slaves
   misc_regs i_misc_regs (
      .wb_clk    (wb_clk),
      .reset_i   (reset_i),
      .wb_req_i  (s0_req),
      .wb_rsp_o  (s0_rsp),
      .dip_sw_i  (dip_sw_i),
      .push_btn_i(push_btn_i),
      .led_o     (led_o),
      .gpio_o    (gpio_o)
   );

   uart_tx_slave #(
      .CLKDIV_DEFAULT(CLKDIV_DEFAULT),
      .TX_DEPTH_LOG2 (TX_DEPTH_LOG2)
   ) i_uart_tx_slave (
      .wb_clk   (wb_clk),
      .reset_i  (reset_i),
      .wb_req_i (s1_req),
      .wb_rsp_o (s1_rsp),
      .uart_tx_o(uart_tx_o)
   );

endmodule

//--- uart_tx_slave.sv
`timescale 1ns/10ps

module uart_tx_slave #(
   parameter int CLKDIV_DEFAULT = 278,
   parameter int TX_DEPTH_LOG2  = 2
) (
   input  logic                   wb_clk,
   input  logic                   reset_i,
   input  host_core_pkg::wb_m2s_t wb_req_i,
   output host_core_pkg::wb_s2m_t wb_rsp_o,
   output logic                   uart_tx_o
);
   import host_core_pkg::*;

   localparam int DEPTH = 1 << TX_DEPTH_LOG2;
   localparam int CNT_W = TX_DEPTH_LOG2 + 1;

   logic [15:0]              clkdiv_q;
   logic [7:0]               mem [DEPTH];
   logic [TX_DEPTH_LOG2-1:0] wr_ptr_q;
   logic [TX_DEPTH_LOG2-1:0] rd_ptr_q;
   logic [CNT_W-1:0]         count_q;
   logic                     ack_q;
   wb_dat_t                  rdata_q;
   wb_dat_t                  status;
   logic [2:0]               reg_idx;
   logic                     access;
   logic                     full;
   logic                     push;
   logic                     pop;

   uart_state_t state_q;
   logic [15:0] baud_cnt_q;
   logic [2:0]  bit_idx_q;
   logic [7:0]  shift_q;
   logic        tx_q;
   logic        bit_end;

   ////////////////////////////////////////
   // Bus side
   assign reg_idx = wb_req_i.adr[4:2];
   // One access per transfer, the cycle before ack
   assign access  = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
   assign full    = (count_q == CNT_W'(DEPTH));
   // Writes into a full FIFO are acked and dropped
   assign push    = access & wb_req_i.we & (reg_idx == UART_REG_TXDATA) & ~full;
   assign pop     = (state_q == IDLE) & (count_q != '0);

   always_comb begin
      status                = '0;
      status[0]             = full;
      status[1]             = (state_q != IDLE);
      status[8 +: CNT_W]    = count_q;
   end

   always_ff @(posedge wb_clk) begin
      if (reset_i) begin
         ack_q    <= 1'b0;
         clkdiv_q <= 16'(CLKDIV_DEFAULT);
      end else begin
         ack_q <= access;
         if (access & wb_req_i.we & (reg_idx == UART_REG_CLKDIV)) begin
            clkdiv_q <= wb_req_i.dat;
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (access) begin
         case (reg_idx)
            UART_REG_CLKDIV: rdata_q <= clkdiv_q;
            UART_REG_STATUS: rdata_q <= status;
            default:         rdata_q <= '0;
         endcase
      end
   end

   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.dat = rdata_q;

   ////////////////////////////////////////
   // Transmit FIFO
   always_ff @(posedge wb_clk) begin
      if (push) begin
         mem[wr_ptr_q] <= wb_req_i.dat[7:0];
      end
   end

   always_ff @(posedge wb_clk) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         if (push & ~pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop & ~push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // 8N1 serializer, LSB first
   assign bit_end = (baud_cnt_q == clkdiv_q - 16'd1);

   always_ff @(posedge wb_clk) begin
      if (reset_i) begin
         state_q <= IDLE;
         tx_q    <= 1'b1;
      end else begin
         case (state_q)
            IDLE: begin
               if (pop) begin
                  shift_q    <= mem[rd_ptr_q];
                  baud_cnt_q <= '0;
                  tx_q       <= 1'b0;
                  state_q    <= START;
               end
            end
            START: begin
               baud_cnt_q <= baud_cnt_q + 16'd1;
               if (bit_end) begin
                  baud_cnt_q <= '0;
                  bit_idx_q  <= '0;
                  tx_q       <= shift_q[0];
                  shift_q    <= shift_q >> 1;
                  state_q    <= DATA;
               end
            end
            DATA: begin
               baud_cnt_q <= baud_cnt_q + 16'd1;
               if (bit_end) begin
                  baud_cnt_q <= '0;
                  if (bit_idx_q == 3'd7) begin
                     tx_q    <= 1'b1;
                     state_q <= STOP;
                  end else begin
                     bit_idx_q <= bit_idx_q + 3'd1;
                     tx_q      <= shift_q[0];
                     shift_q   <= shift_q >> 1;
                  end
               end
            end
            STOP: begin
               baud_cnt_q <= baud_cnt_q + 16'd1;
               if (bit_end) begin
                  state_q <= IDLE;
               end
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   assign uart_tx_o = tx_q;

endmodule

//--- misc_regs.sv
`timescale 1ns/10ps

module misc_regs (
   input  logic                   wb_clk,
   input  logic                   reset_i,
   input  host_core_pkg::wb_m2s_t wb_req_i,
   output host_core_pkg::wb_s2m_t wb_rsp_o,
   input  logic [7:0]             dip_sw_i,
   input  logic [2:0]             push_btn_i,
   output logic [2:0]             led_o,
   output logic [3:0]             gpio_o
);
   import host_core_pkg::*;

   wb_dat_t    fast_q;
   logic [3:0] gpio_q;
   logic [6:0] offset;
   logic       wr_en;

   assign offset = wb_req_i.adr[6:0];
   assign wr_en  = wb_req_i.cyc & wb_req_i.stb & wb_req_i.we;

   always_ff @(posedge wb_clk) begin
      if (reset_i) begin
         fast_q <= '0;
         gpio_q <= '0;
      end else if (wr_en) begin
         if (offset == MISC_REG_FAST) begin
            fast_q <= wb_req_i.dat;
         end
         if (offset == MISC_REG_GPIOS) begin
            gpio_q <= wb_req_i.dat[3:0];
         end
      end
   end

   // GPIO is write-only and falls through to the filler
   always_comb begin
      wb_rsp_o.ack = wb_req_i.cyc & wb_req_i.stb;
      case (offset)
         MISC_REG_FAST:     wb_rsp_o.dat = fast_q;
         MISC_REG_SWITCHES: wb_rsp_o.dat = {5'b0, push_btn_i, dip_sw_i};
         default:           wb_rsp_o.dat = MISC_FILLER;
      endcase
   end

   // Board LED order is swapped on the low two bits
   assign led_o  = {fast_q[2], fast_q[0], fast_q[1]};
   assign gpio_o = gpio_q;

endmodule

//--- wb_single_master_ic.sv
`timescale 1ns/10ps

module wb_single_master_ic (
   input  logic                   wb_clk,
   input  logic                   reset_i,
   input  host_core_pkg::wb_m2s_t m_req_i,
   output host_core_pkg::wb_s2m_t m_rsp_o,
   output host_core_pkg::wb_m2s_t s0_req_o,
   input  host_core_pkg::wb_s2m_t s0_rsp_i,
   output host_core_pkg::wb_m2s_t s1_req_o,
   input  host_core_pkg::wb_s2m_t s1_rsp_i
);
   import host_core_pkg::*;

   // Clock and reset serve the bound bus checks only

   slot_t slot;
   logic  hit_misc;
   logic  hit_uart;

   assign slot     = m_req_i.adr[SLOT_LSB +: $bits(slot_t)];
   assign hit_misc = (slot == SLOT_MISC);
   assign hit_uart = (slot == SLOT_UART);

   ////////////////////////////////////////
   // Request fan-out
   always_comb begin
      s0_req_o     = m_req_i;
      s0_req_o.cyc = m_req_i.cyc & hit_misc;
      s0_req_o.stb = m_req_i.stb & hit_misc;

      s1_req_o     = m_req_i;
      s1_req_o.cyc = m_req_i.cyc & hit_uart;
      s1_req_o.stb = m_req_i.stb & hit_uart;
   end

   ////////////////////////////////////////
   // Response mux
   always_comb begin
      case (slot)
         SLOT_MISC: begin
            m_rsp_o = s0_rsp_i;
         end
         SLOT_UART: begin
            m_rsp_o = s1_rsp_i;
         end
         default: begin
            // Empty slot answers at once so the host never stalls
            m_rsp_o.ack = m_req_i.cyc & m_req_i.stb;
            m_rsp_o.dat = '0;
         end
      endcase
   end

endmodule

//--- host_bus_bridge.sv
`timescale 1ns/10ps

module host_bus_bridge (
   input  logic                   wb_clk,
   input  logic                   reset_i,
   input  logic                   host_req_i,
   input  logic                   host_we_i,
   input  host_core_pkg::wb_adr_t host_adr_i,
   input  host_core_pkg::wb_dat_t host_wdata_i,
   output logic                   host_busy_o,
   output logic                   host_done_o,
   output host_core_pkg::wb_dat_t host_rdata_o,
   output host_core_pkg::wb_m2s_t wb_req_o,
   input  host_core_pkg::wb_s2m_t wb_rsp_i
);
   import host_core_pkg::*;

   logic    cyc_q;
   logic    done_q;
   logic    we_q;
   wb_adr_t adr_q;
   wb_dat_t wdata_q;
   wb_dat_t rdata_q;
   logic    accept;
   logic    ack_seen;

   // Only one transfer in flight, new strobes ignored while busy
   assign accept   = host_req_i & ~cyc_q;
   assign ack_seen = cyc_q & wb_rsp_i.ack;

   always_ff @(posedge wb_clk) begin
      if (reset_i) begin
         cyc_q  <= 1'b0;
         done_q <= 1'b0;
      end else begin
         done_q <= ack_seen;
         if (accept) begin
            cyc_q <= 1'b1;
         end else if (ack_seen) begin
            cyc_q <= 1'b0;
         end
      end
   end

   // Latched request and returned word
   always_ff @(posedge wb_clk) begin
      if (accept) begin
         we_q    <= host_we_i;
         adr_q   <= host_adr_i;
         wdata_q <= host_wdata_i;
      end
      if (ack_seen) begin
         rdata_q <= wb_rsp_i.dat;
      end
   end

   always_comb begin
      wb_req_o.cyc = cyc_q;
      wb_req_o.stb = cyc_q;
      wb_req_o.we  = we_q;
      wb_req_o.adr = adr_q;
      wb_req_o.sel = 2'b11;   // whole words only
      wb_req_o.dat = wdata_q;
   end

   assign host_busy_o  = cyc_q;
   assign host_done_o  = done_q;
   assign host_rdata_o = rdata_q;

endmodule

//--- host_core_pkg.sv
package host_core_pkg;

   ////////////////////////////////////////
   // Bus widths
   typedef logic [10:0] wb_adr_t;
   typedef logic [15:0] wb_dat_t;
   typedef logic [1:0]  wb_sel_t;
   typedef logic [3:0]  slot_t;

   // Master to slave
   typedef struct packed {
      logic    cyc;
      logic    stb;
      logic    we;
      wb_adr_t adr;
      wb_sel_t sel;
      wb_dat_t dat;
   } wb_m2s_t;

   // Slave to master
   typedef struct packed {
      logic    ack;
      wb_dat_t dat;
   } wb_s2m_t;

   ////////////////////////////////////////
   // Slot decode, top four address bits
   localparam int    SLOT_LSB  = 7;
   localparam slot_t SLOT_MISC = 4'd0;
   localparam slot_t SLOT_UART = 4'd1;

   // Slot 0 offsets
   localparam logic [6:0] MISC_REG_FAST     = 7'd4;
   localparam logic [6:0] MISC_REG_SWITCHES = 7'd6;
   localparam logic [6:0] MISC_REG_GPIOS    = 7'd8;
   localparam wb_dat_t    MISC_FILLER       = 16'hBEEF;

   // Slot 1 register indices, address bits 4 to 2
   localparam logic [2:0] UART_REG_CLKDIV = 3'd0;
   localparam logic [2:0] UART_REG_TXDATA = 3'd1;
   localparam logic [2:0] UART_REG_STATUS = 3'd2;

   typedef enum logic [1:0] {
      IDLE,
      START,
      DATA,
      STOP
   } uart_state_t;

endpackage
